// ==== tb.f ====
rv32_isa_pkg.sv
alu_pkg.sv
rv32_decoder.sv
rv32_regfile.sv
rv32_alu.sv
rv32_exec_core.sv
rv32_exec_core_asserts.sv
tb_rv32_exec_core.sv

// ==== Bender.yml ====
package:
  name: rv32_exec_core

sources:
  # Packages first, then the design from the leaves up.
  - files:
      - rv32_isa_pkg.sv
      - alu_pkg.sv
      - rv32_decoder.sv
      - rv32_regfile.sv
      - rv32_alu.sv
      - rv32_exec_core.sv

  # Verification sources.
  - target: test
    files:
      - rv32_exec_core_asserts.sv
      - tb_rv32_exec_core.sv

// ==== tb_rv32_exec_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_rv32_exec_core
  import rv32_isa_pkg::*;
  import alu_pkg::*;
();

  localparam int CLK_PERIOD   = 40;
  localparam int DRIVE_DELAY  = 2;
  localparam int RESET_CYCLES = 4;
  localparam int R_REPS       = 6;
  localparam int I_REPS       = 6;
  localparam int CHAIN_LEN    = 24;
  localparam int TEST_INSTR   = 8 + 62 + 10 * R_REPS + 9 * I_REPS + 15 + 31 + 5 + CHAIN_LEN;
  localparam int TIMEOUT_NS   = (RESET_CYCLES + TEST_INSTR + 20) * CLK_PERIOD;

  typedef struct packed {
    logic                  legal;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       data;
  } expect_t;

  logic                  clk;
  logic                  rst_n;
  logic [31:0]           instr;
  logic                  instr_valid;
  logic                  wb_valid;
  logic [REG_ADDR_W-1:0] wb_rd;
  logic [XLEN-1:0]       wb_data;
  logic                  illegal;

  logic [15:0]     lfsr_state;
  logic [XLEN-1:0] shadow [NUM_REGS]; // Register state as the ISA rules predict it.
  logic [6:0]      bad_opcodes [10];
  string           test_name;
  string           drive_name;
  int              issued;
  int              checked;

  rv32_exec_core dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr       (instr),
    .instr_valid (instr_valid),
    .wb_valid    (wb_valid),
    .wb_rd       (wb_rd),
    .wb_data     (wb_data),
    .illegal     (illegal)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // ##########################################################################
  // Stimulus helpers
  // ##########################################################################

  // Taps 16, 14, 13 and 11 give a maximal length sequence.
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic logic [REG_ADDR_W-1:0] rand_reg();
    return REG_ADDR_W'(rand_bits(REG_ADDR_W));
  endfunction

  function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, OP};
  endfunction

  function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1);
    return {imm, rs1, f3, rd, OP_IMM};
  endfunction

  function automatic logic [31:0] u_word(input logic [19:0] hi, input logic [4:0] rd);
    return {hi, rd, LUI};
  endfunction

  task automatic issue(input logic [31:0] word);
    @(posedge clk);
    #(DRIVE_DELAY);
    instr       = word;
    instr_valid = 1'b1;
    drive_name  = test_name;
    issued++;
  endtask

  task automatic go_idle();
    @(posedge clk);
    #(DRIVE_DELAY);
    instr_valid = 1'b0;
  endtask

  // ##########################################################################
  // Reference model and checking
  // ##########################################################################

  function automatic expect_t ref_exec(input logic [31:0] word,
                                       input logic [XLEN-1:0] regs_in [NUM_REGS]);
    expect_t         e;
    logic [6:0]      opc;
    logic [2:0]      f3;
    logic [6:0]      f7;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [4:0]      sh;
    logic            alt;
    opc    = word[6:0];
    f3     = word[FUNCT3_HI:FUNCT3_LO];
    f7     = word[FUNCT7_HI:FUNCT7_LO];
    a      = regs_in[word[RS1_LO +: REG_ADDR_W]];
    b      = '0;
    alt    = (f7 == FUNCT7_ALT);
    e.rd   = word[RD_LO +: REG_ADDR_W];
    e.data = '0;
    if (opc == LUI) begin
      e.legal = 1'b1;
      e.data  = {word[31:12], 12'b0};
      return e;
    end else if (opc == OP) begin
      b       = regs_in[word[RS2_LO +: REG_ADDR_W]];
      e.legal = (f7 == 7'b0) || (alt && (f3 == 3'b000 || f3 == 3'b101));
    end else if (opc == OP_IMM) begin
      b       = {{20{word[31]}}, word[31:20]};
      e.legal = (f3 != 3'b001 && f3 != 3'b101) || (f7 == 7'b0) || (alt && f3 == 3'b101);
    end else begin
      e.legal = 1'b0; // Loads, stores, jumps, branches, AUIPC and unknown opcodes.
      return e;
    end
    if (!e.legal) begin
      return e;
    end
    sh = b[4:0];
    case (f3)
      3'b000:  e.data = (opc == OP && alt) ? a - b : a + b;
      3'b001:  e.data = a << sh;
      3'b010:  e.data = {{(XLEN-1){1'b0}}, ($signed(a) < $signed(b))};
      3'b011:  e.data = {{(XLEN-1){1'b0}}, (a < b)};
      3'b100:  e.data = a ^ b;
      3'b101:  e.data = alt ? $unsigned($signed(a) >>> sh) : a >> sh;
      3'b110:  e.data = a | b;
      default: e.data = a & b;
    endcase
    return e;
  endfunction

  task automatic compare_value(input string test, input string field,
                               input logic [XLEN-1:0] exp, input logic [XLEN-1:0] act);
    if (exp !== act) begin
      $display("Mismatch in %s, %s: expected 0x%08h, actual 0x%08h", test, field, exp, act);
      $display("Verification failed");
      $fatal(1, "Stopped at the first mismatch.");
    end
  endtask

  // Inputs are stable at the edge, outputs are sampled half a cycle later.
  always begin : compare_proc
    logic [31:0] seen_instr;
    logic        seen_valid;
    string       seen_name;
    expect_t     e;
    @(posedge clk);
    seen_valid = instr_valid;
    seen_instr = instr;
    seen_name  = drive_name;
    @(negedge clk);
    if (seen_valid) begin
      e = ref_exec(seen_instr, shadow);
      compare_value(seen_name, "wb_valid", XLEN'(e.legal), XLEN'(wb_valid));
      compare_value(seen_name, "illegal", XLEN'(!e.legal), XLEN'(illegal));
      if (e.legal) begin
        compare_value(seen_name, "wb_rd", XLEN'(e.rd), XLEN'(wb_rd));
        compare_value(seen_name, "wb_data", e.data, wb_data);
        if (e.rd != '0) begin
          shadow[e.rd] = e.data;
        end
      end
      checked++;
    end
  end

  initial begin : watchdog
    #(TIMEOUT_NS);
    $display("Timeout: the run did not finish within %0d ns.", TIMEOUT_NS);
    $display("Verification failed");
    $fatal(1, "Watchdog expired.");
  end

  // ##########################################################################
  // Test sequence
  // ##########################################################################

  initial begin : stimulus
    logic [2:0]            f3;
    logic [6:0]            f7;
    logic [11:0]           imm12;
    logic [REG_ADDR_W-1:0] prev;
    logic [REG_ADDR_W-1:0] nxt;
    clk         = 1'b0;
    rst_n       = 1'b0;
    instr       = '0;
    instr_valid = 1'b0;
    lfsr_state  = 16'd33458;
    issued      = 0;
    checked     = 0;
    for (int i = 0; i < NUM_REGS; i++) begin
      shadow[i] = '0;
    end
    bad_opcodes = '{LOAD, STORE, BRANCH, JAL, JALR, AUIPC, 7'h7f, 7'h0b, 7'h00, 7'h5b};
    repeat (RESET_CYCLES) @(posedge clk);
    #(DRIVE_DELAY);
    rst_n = 1'b1;

    test_name = "reset";
    for (int r = 1; r <= 8; r++) begin
      issue(r_word(7'b0, 3'b000, 5'(r), 5'd5, 5'd6));
    end

    test_name = "load";
    for (int r = 1; r < NUM_REGS; r++) begin
      issue(u_word(20'(rand_bits(20)), 5'(r)));
      issue(i_word(12'(rand_bits(12)), 3'b000, 5'(r), 5'(r)));
    end

    test_name = "r_type";
    for (int op = 0; op < 10; op++) begin
      f3 = (op < 8) ? op[2:0] : ((op == 8) ? 3'b000 : 3'b101); // SUB and SRA last.
      f7 = (op < 8) ? 7'b0 : FUNCT7_ALT;
      repeat (R_REPS) begin
        issue(r_word(f7, f3, rand_reg(), rand_reg(), rand_reg()));
      end
    end

    test_name = "i_type";
    for (int op = 0; op < 8; op++) begin
      repeat (I_REPS) begin
        if (op == 1) begin
          imm12 = {7'b0, 5'(rand_bits(5))};
        end else if (op == 5) begin
          imm12 = {((rand_bits(1) != 0) ? FUNCT7_ALT : 7'b0), 5'(rand_bits(5))};
        end else begin
          imm12 = 12'(rand_bits(12));
        end
        issue(i_word(imm12, op[2:0], rand_reg(), rand_reg()));
      end
    end
    repeat (I_REPS) issue(u_word(20'(rand_bits(20)), rand_reg()));

    test_name = "illegal";
    issue(r_word(7'b0000001, 3'b001, rand_reg(), rand_reg(), rand_reg()));
    issue(r_word(7'b0000001, 3'b101, rand_reg(), rand_reg(), rand_reg()));
    issue(r_word(7'b0000001, 3'b000, rand_reg(), rand_reg(), rand_reg()));
    issue(r_word(FUNCT7_ALT, 3'b001, rand_reg(), rand_reg(), rand_reg()));
    issue(i_word({FUNCT7_ALT, 5'(rand_bits(5))}, 3'b001, rand_reg(), rand_reg()));
    for (int k = 0; k < 10; k++) begin
      issue({25'(rand_bits(25)), bad_opcodes[k]});
    end
    for (int r = 1; r < NUM_REGS; r++) begin
      issue(r_word(7'b0, 3'b000, 5'(r), 5'(r), 5'd0)); // Reads back each register.
    end

    test_name = "x0";
    issue(i_word(12'(rand_bits(12)), 3'b000, 5'd0, 5'd1));
    issue(r_word(7'b0, 3'b000, 5'd0, 5'd1, 5'd2));
    issue(u_word(20'(rand_bits(20)), 5'd0));
    issue(r_word(7'b0, 3'b000, 5'd3, 5'd0, 5'd0));
    issue(r_word(7'b0, 3'b110, 5'd4, 5'd0, 5'd5));

    test_name = "chain";
    prev = 5'd1;
    for (int i = 0; i < CHAIN_LEN; i++) begin
      nxt = rand_reg();
      f3  = 3'(rand_bits(3));
      f7  = ((f3 == 3'b000 || f3 == 3'b101) && rand_bits(1) != 0) ? FUNCT7_ALT : 7'b0;
      if (rand_bits(1) != 0) begin
        issue(r_word(f7, f3, nxt, prev, rand_reg()));
      end else if (f3 == 3'b001 || f3 == 3'b101) begin
        issue(i_word({f7, 5'(rand_bits(5))}, f3, nxt, prev));
      end else begin
        issue(i_word(12'(rand_bits(12)), f3, nxt, prev));
      end
      prev = nxt;
    end

    go_idle();
    repeat (3) @(posedge clk);
    if (checked == issued) begin
      $display("Verification passed");
      $finish;
    end else begin
      $display("Only %0d of %0d instructions were checked.", checked, issued);
      $display("Verification failed");
      $fatal(1, "Run ended with errors.");
    end
  end

endmodule

`default_nettype wire

// ==== rv32_exec_core_asserts.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv32_exec_core_asserts (
  input wire logic clk,
  input wire logic rst_n,
  input wire logic instr_valid,
  input wire logic wb_valid,
  input wire logic illegal
);

  // ##########################################################################
  // Write-back outputs
  // ##########################################################################

  a_exclusive : assert property (@(posedge clk) disable iff (!rst_n)
    !(wb_valid && illegal))
    else $error("wb_valid and illegal are high in the same cycle.");

  // No input in one cycle means no output in the next.
  a_idle : assert property (@(posedge clk) disable iff (!rst_n)
    !instr_valid |=> (!wb_valid && !illegal))
    else $error("Output pulse without a valid instruction the cycle before.");

  a_reset : assert property (@(posedge clk)
    !rst_n |-> (!wb_valid && !illegal))
    else $error("Output pulse while reset is asserted.");

endmodule

bind rv32_exec_core rv32_exec_core_asserts u_asserts (
  .clk         (clk),
  .rst_n       (rst_n),
  .instr_valid (instr_valid),
  .wb_valid    (wb_valid),
  .illegal     (illegal)
);

`default_nettype wire

// ==== rv32_exec_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv32_exec_core
  import alu_pkg::*;
(
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic [31:0]           instr,
  input  wire logic                  instr_valid,
  output logic                       wb_valid,
  output logic      [REG_ADDR_W-1:0] wb_rd,
  output logic      [XLEN-1:0]       wb_data,
  output logic                       illegal
);

  alu_op_t               alu_op;
  logic [REG_ADDR_W-1:0] rs1;
  logic [REG_ADDR_W-1:0] rs2;
  logic [REG_ADDR_W-1:0] rd;
  logic [XLEN-1:0]       imm;
  logic                  use_imm;
  logic                  legal;
  logic [XLEN-1:0]       rs1_data;
  logic [XLEN-1:0]       rs2_data;
  logic [XLEN-1:0]       op_b;
  logic [XLEN-1:0]       result;
  logic                  we;

  // #########################################################################
  // Decode, operand read and execute
  // #########################################################################

  rv32_decoder u_decoder (
    .instr   (instr),
    .format  (),
    .is_jalr (),
    .alu_op  (alu_op),
    .rs1     (rs1),
    .rs2     (rs2),
    .rd      (rd),
    .imm     (imm),
    .use_imm (use_imm),
    .legal   (legal)
  );

  rv32_regfile u_regfile (
    .clk      (clk),
    .rst_n    (rst_n),
    .rs1      (rs1),
    .rs2      (rs2),
    .we       (we),
    .waddr    (rd),
    .wdata    (result),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  assign op_b = use_imm ? imm : rs2_data;

  rv32_alu u_alu (
    .alu_op (alu_op),
    .a      (rs1_data),
    .b      (op_b),
    .result (result)
  );

  // Destination x0 still reports write-back but never reaches the register file.
  assign we = instr_valid && legal && (rd != '0);

  // #########################################################################
  // Write-back stage
  // #########################################################################

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_valid <= 1'b0;
      illegal  <= 1'b0;
      wb_rd    <= '0;
      wb_data  <= '0;
    end else begin
      wb_valid <= instr_valid && legal;
      illegal  <= instr_valid && !legal; // Illegal words pulse here and write nothing.
      if (instr_valid && legal) begin
        wb_rd   <= rd;
        wb_data <= result;
      end
    end
  end

endmodule

`default_nettype wire

// ==== rv32_alu.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv32_alu
  import alu_pkg::*;
(
  input  alu_op_t              alu_op,
  input  wire logic [XLEN-1:0] a,
  input  wire logic [XLEN-1:0] b,
  output logic      [XLEN-1:0] result
);

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  assign shamt       = b[4:0]; // Upper bits of b play no part in a shift.
  assign lt_signed   = ($signed(a) < $signed(b));
  assign lt_unsigned = (a < b);

  // #########################################################################
  // Operation select
  // #########################################################################

  always_comb begin
    case (alu_op)
      ALU_ADD: begin
        result = a + b;
      end
      ALU_SUB: begin
        result = a - b;
      end
      ALU_SLL: begin
        result = a << shamt;
      end
      ALU_SLT: begin
        result = {{(XLEN-1){1'b0}}, lt_signed};
      end
      ALU_SLTU: begin
        result = {{(XLEN-1){1'b0}}, lt_unsigned};
      end
      ALU_XOR: begin
        result = a ^ b;
      end
      ALU_SRL: begin
        result = a >> shamt;
      end
      ALU_SRA: begin
        result = $unsigned($signed(a) >>> shamt); // Sign bit fills from the left.
      end
      ALU_OR: begin
        result = a | b;
      end
      ALU_AND: begin
        result = a & b;
      end
      ALU_PASS_B: begin
        result = b;
      end
      default: begin
        result = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== rv32_regfile.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv32_regfile
  import alu_pkg::*;
(
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic [REG_ADDR_W-1:0] rs1,
  input  wire logic [REG_ADDR_W-1:0] rs2,
  input  wire logic                  we,
  input  wire logic [REG_ADDR_W-1:0] waddr,
  input  wire logic [XLEN-1:0]       wdata,
  output logic      [XLEN-1:0]       rs1_data,
  output logic      [XLEN-1:0]       rs2_data
);

  // x0 has no storage; only registers 1 to 31 exist.
  logic [XLEN-1:0] regs [1:NUM_REGS-1];

  // #########################################################################
  // Write port
  // #########################################################################

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (waddr != '0)) begin
      regs[waddr] <= wdata; // Writes to x0 fall away here.
    end
  end

  // #########################################################################
  // Read ports
  // #########################################################################

  // A value written at an edge is seen by the instruction of the next cycle.
  always_comb begin
    if (rs1 == '0) begin
      rs1_data = '0;
    end else begin
      rs1_data = regs[rs1];
    end
  end

  always_comb begin
    if (rs2 == '0) begin
      rs2_data = '0;
    end else begin
      rs2_data = regs[rs2];
    end
  end

endmodule

`default_nettype wire

// ==== rv32_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv32_decoder
  import rv32_isa_pkg::*;
  import alu_pkg::*;
(
  input  wire logic [31:0]           instr,
  output instr_format_t              format,
  output logic                       is_jalr,
  output alu_op_t                    alu_op,
  output logic [REG_ADDR_W-1:0]      rs1,
  output logic [REG_ADDR_W-1:0]      rs2,
  output logic [REG_ADDR_W-1:0]      rd,
  output logic [XLEN-1:0]            imm,
  output logic                       use_imm,
  output logic                       legal
);

  opcode_t    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       f7_zero;
  logic       f7_alt;
  alu_op_t    r_op;
  alu_op_t    i_op;

  assign opcode  = opcode_t'(instr[6:0]);
  assign funct3  = instr[FUNCT3_HI:FUNCT3_LO];
  assign funct7  = instr[FUNCT7_HI:FUNCT7_LO];
  assign f7_zero = (funct7 == 7'b0000000);
  assign f7_alt  = (funct7 == FUNCT7_ALT);

  assign rd  = instr[RD_LO +: REG_ADDR_W];
  assign rs1 = instr[RS1_LO +: REG_ADDR_W];
  assign rs2 = instr[RS2_LO +: REG_ADDR_W];

  // #########################################################################
  // Format classification
  // #########################################################################

  // AUIPC shares the U format with LUI but is never executed.
  always_comb begin
    is_jalr = 1'b0;
    case (opcode)
      OP:      format = R_TYPE;
      OP_IMM:  format = I_TYPE;
      LOAD:    format = L_TYPE;
      STORE:   format = S_TYPE;
      BRANCH:  format = B_TYPE;
      LUI:     format = U_TYPE;
      AUIPC:   format = U_TYPE;
      JAL:     format = J_TYPE;
      JALR: begin
        format  = J_TYPE; // Counted with jal, told apart by the flag.
        is_jalr = 1'b1;
      end
      default: format = UNDEFINED;
    endcase
  end

  // #########################################################################
  // Operation lookups
  // #########################################################################

  // Register-register map. Any funct7 other than zero or ALT is rejected.
  always_comb begin
    case (funct3)
      3'b000:  r_op = f7_zero ? ALU_ADD : (f7_alt ? ALU_SUB : ALU_INVALID);
      3'b001:  r_op = f7_zero ? ALU_SLL : ALU_INVALID;
      3'b010:  r_op = f7_zero ? ALU_SLT : ALU_INVALID;
      3'b011:  r_op = f7_zero ? ALU_SLTU : ALU_INVALID;
      3'b100:  r_op = f7_zero ? ALU_XOR : ALU_INVALID;
      3'b101:  r_op = f7_zero ? ALU_SRL : (f7_alt ? ALU_SRA : ALU_INVALID);
      3'b110:  r_op = f7_zero ? ALU_OR : ALU_INVALID;
      default: r_op = f7_zero ? ALU_AND : ALU_INVALID;
    endcase
  end

  // Register-immediate map. The upper bits are immediate except on shifts.
  always_comb begin
    case (funct3)
      3'b000:  i_op = ALU_ADD;
      3'b001:  i_op = f7_zero ? ALU_SLL : ALU_INVALID;
      3'b010:  i_op = ALU_SLT;
      3'b011:  i_op = ALU_SLTU;
      3'b100:  i_op = ALU_XOR;
      3'b101:  i_op = f7_zero ? ALU_SRL : (f7_alt ? ALU_SRA : ALU_INVALID);
      3'b110:  i_op = ALU_OR;
      default: i_op = ALU_AND;
    endcase
  end

  always_comb begin
    case (format)
      R_TYPE:  alu_op = r_op;
      I_TYPE:  alu_op = i_op;
      U_TYPE:  alu_op = (opcode == LUI) ? ALU_PASS_B : ALU_INVALID; // AUIPC needs the PC.
      default: alu_op = ALU_INVALID;
    endcase
  end

  // Upper immediate for LUI, sign-extended 12-bit immediate otherwise.
  assign imm = (format == U_TYPE) ? {instr[31:12], 12'b0}
                                  : {{(XLEN-12){instr[31]}}, instr[31:20]};

  assign use_imm = (format == I_TYPE) || (format == U_TYPE);
  assign legal   = (alu_op != ALU_INVALID); // Only executable formats get a real operation.

endmodule

`default_nettype wire

// ==== alu_pkg.sv ====
`default_nettype none

package alu_pkg;

  // #########################################################################
  // Data path sizes
  // #########################################################################

  localparam int unsigned XLEN       = 32;
  localparam int unsigned REG_ADDR_W = 5;
  localparam int unsigned NUM_REGS   = 2 ** REG_ADDR_W;

  // #########################################################################
  // ALU operations
  // #########################################################################

  typedef enum logic [3:0] {
    ALU_ADD     = 4'd0,
    ALU_SUB     = 4'd1,
    ALU_SLL     = 4'd2,
    ALU_SLT     = 4'd3,
    ALU_SLTU    = 4'd4,
    ALU_XOR     = 4'd5,
    ALU_SRL     = 4'd6,
    ALU_SRA     = 4'd7,
    ALU_OR      = 4'd8,
    ALU_AND     = 4'd9,
    ALU_PASS_B  = 4'd10, // Second operand straight through, used by LUI.
    ALU_INVALID = 4'd15
  } alu_op_t;

endpackage

`default_nettype wire

// ==== rv32_isa_pkg.sv ====
`default_nettype none

package rv32_isa_pkg;

  // #########################################################################
  // Major opcodes
  // #########################################################################

  // Bits 6:0 of every 32-bit instruction word.
  typedef enum logic [6:0] {
    LOAD   = 7'd3,
    OP_IMM = 7'd19,
    AUIPC  = 7'd23,
    STORE  = 7'd35,
    OP     = 7'd51,
    LUI    = 7'd55,
    BRANCH = 7'd99,
    JALR   = 7'd103,
    JAL    = 7'd111
  } opcode_t;

  // #########################################################################
  // Instruction formats
  // #########################################################################

  // UNDEFINED is a real code so that unknown opcodes never produce x.
  typedef enum logic [2:0] {
    R_TYPE    = 3'd0,
    I_TYPE    = 3'd1,
    L_TYPE    = 3'd2,
    S_TYPE    = 3'd3,
    B_TYPE    = 3'd4,
    U_TYPE    = 3'd5,
    J_TYPE    = 3'd6,
    UNDEFINED = 3'd7
  } instr_format_t;

  // #########################################################################
  // Field positions
  // #########################################################################

  localparam int unsigned FUNCT3_HI = 14;
  localparam int unsigned FUNCT3_LO = 12;
  localparam int unsigned FUNCT7_HI = 31;
  localparam int unsigned FUNCT7_LO = 25;

  // Low bit of each 5-bit register index.
  localparam int unsigned RD_LO  = 7;
  localparam int unsigned RS1_LO = 15;
  localparam int unsigned RS2_LO = 20;

  localparam logic [6:0] FUNCT7_ALT = 7'b0100000; // Selects SUB and SRA.

endpackage

`default_nettype wire
